// ==== noc_axis_bridge.f ====
noc_bridge_pkg.sv
credit_sync.sv
flit_fifo.sv
rr_beat_arbiter.sv
bridge_ctrl.sv
noc_axis_bridge.sv
noc_axis_bridge_sva.sv
tb_noc_axis_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run into sim.log, then judge the run from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_noc_axis_bridge -f noc_axis_bridge.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "Test failures found" >> sim.log

cat sim.log

grep -q "Test failures found" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || { echo "Simulation finished clean"; exit 0; }

// ==== tb_noc_axis_bridge.sv ====
// Loopback testbench for the bridge, sends flits on both channels and checks each one delivered
module tb_noc_axis_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] Seed = 32'h9860;
  localparam int ReqOnlyFlits  = 12;
  localparam int MixFlits      = 10;
  localparam int StallReqFlits = 20;
  localparam int StallRspFlits = 6;
  localparam int RandFlits     = 16;
  localparam int ForceFlits    = int'(noc_bridge_pkg::ForceSendThresh);
  localparam int TotalFlits    = ReqOnlyFlits + 2 * MixFlits + StallReqFlits + StallRspFlits
                                 + 2 * RandFlits + ForceFlits;
  localparam int TimeoutCycles = TotalFlits * 40 + 400;
  // Queue, synchronizer register and two output-stage entries
  localparam int MaxHeld       = noc_bridge_pkg::NumCred + 3;

  logic                              clk_i = 1'b0;
  logic                              rst_i = 1'b1;
  logic                              noc_req_valid_i = 1'b0;
  logic [noc_bridge_pkg::FlitW-1:0]  noc_req_data_i = '0;
  logic                              noc_req_ready_o;
  logic                              noc_rsp_valid_i = 1'b0;
  logic [noc_bridge_pkg::FlitW-1:0]  noc_rsp_data_i = '0;
  logic                              noc_rsp_ready_o;
  logic                              noc_req_valid_o;
  logic [noc_bridge_pkg::FlitW-1:0]  noc_req_data_o;
  logic                              noc_req_ready_i = 1'b1;
  logic                              noc_rsp_valid_o;
  logic [noc_bridge_pkg::FlitW-1:0]  noc_rsp_data_o;
  logic                              noc_rsp_ready_i = 1'b1;
  logic                              axis_out_tvalid_o;
  logic [noc_bridge_pkg::TdataW-1:0] axis_out_tdata_o;
  logic [noc_bridge_pkg::TuserW-1:0] axis_out_tuser_o;
  logic                              axis_out_tready_i;
  logic                              axis_in_tvalid_i;
  logic [noc_bridge_pkg::TdataW-1:0] axis_in_tdata_i;
  logic [noc_bridge_pkg::TuserW-1:0] axis_in_tuser_i;
  logic                              axis_in_tready_o;

  // Loop gate, low blocks both valid and ready on the link
  logic        loop_en = 1'b1;
  logic        loop_random = 1'b0;
  logic [31:0] rand_state = Seed;

  int    req_target = 0;
  int    rsp_target = 0;
  int    sent_req = 0;
  int    sent_rsp = 0;
  int    got_req = 0;
  int    got_rsp = 0;
  int    loop_data_beats = 0;
  int    credit_only_beats = 0;
  int    cmp_errors = 0;
  int    main_errors = 0;
  int    test_err_base = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name = "reset";

  noc_axis_bridge UUT (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .noc_req_valid_i   (noc_req_valid_i),
    .noc_req_data_i    (noc_req_data_i),
    .noc_req_ready_o   (noc_req_ready_o),
    .noc_rsp_valid_i   (noc_rsp_valid_i),
    .noc_rsp_data_i    (noc_rsp_data_i),
    .noc_rsp_ready_o   (noc_rsp_ready_o),
    .noc_req_valid_o   (noc_req_valid_o),
    .noc_req_data_o    (noc_req_data_o),
    .noc_req_ready_i   (noc_req_ready_i),
    .noc_rsp_valid_o   (noc_rsp_valid_o),
    .noc_rsp_data_o    (noc_rsp_data_o),
    .noc_rsp_ready_i   (noc_rsp_ready_i),
    .axis_out_tvalid_o (axis_out_tvalid_o),
    .axis_out_tdata_o  (axis_out_tdata_o),
    .axis_out_tuser_o  (axis_out_tuser_o),
    .axis_out_tready_i (axis_out_tready_i),
    .axis_in_tvalid_i  (axis_in_tvalid_i),
    .axis_in_tdata_i   (axis_in_tdata_i),
    .axis_in_tuser_i   (axis_in_tuser_i),
    .axis_in_tready_o  (axis_in_tready_o)
  );

  assign axis_in_tvalid_i  = axis_out_tvalid_o && loop_en;
  assign axis_in_tdata_i   = axis_out_tdata_o;
  assign axis_in_tuser_i   = axis_out_tuser_o;
  assign axis_out_tready_i = axis_in_tready_o && loop_en;

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Request flits take the odd steps of the seed sequence, response flits the even ones
  function automatic logic [31:0] ref_payload(input logic chan, input int n);
    logic [31:0] s;
    int          steps;
    s     = Seed;
    steps = 2 * n + 1 + int'(chan);
    repeat (steps) s = xorshift32(s);
    return s;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act, inout int errs);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", what, exp, act);
      errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = cmp_errors + main_errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (cmp_errors + main_errors != test_err_base) begin
      tests_failed++;
      $display("Test %s: FAILED", test_name);
    end else begin
      $display("Test %s: ok", test_name);
    end
  endtask

  task automatic wait_drained();
    while (sent_req != req_target || sent_rsp != rsp_target
           || got_req != req_target || got_rsp != rsp_target) begin
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_i && sent_req < req_target) begin
      noc_req_valid_i = 1'b1;
      noc_req_data_i  = ref_payload(noc_bridge_pkg::ChanReq, sent_req);
    end else begin
      noc_req_valid_i = 1'b0;
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && sent_rsp < rsp_target) begin
      noc_rsp_valid_i = 1'b1;
      noc_rsp_data_i  = ref_payload(noc_bridge_pkg::ChanRsp, sent_rsp);
    end else begin
      noc_rsp_valid_i = 1'b0;
    end
  end

  // Random gating of the loop, about three cycles in four open
  always @(negedge clk_i) begin
    if (loop_random) begin
      rand_state = xorshift32(rand_state);
      loop_en    = rand_state[6] || rand_state[2];
    end else begin
      loop_en = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Transfer counting and compare
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (noc_req_valid_i && noc_req_ready_o) begin
        sent_req <= sent_req + 1;
      end
      if (noc_rsp_valid_i && noc_rsp_ready_o) begin
        sent_rsp <= sent_rsp + 1;
      end
      if (axis_out_tvalid_o && axis_out_tready_i) begin
        if (axis_out_tuser_o[noc_bridge_pkg::TuserW-1]) begin
          loop_data_beats <= loop_data_beats + 1;
        end else begin
          credit_only_beats <= credit_only_beats + 1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (noc_req_valid_o && noc_req_ready_i) begin
        check_value($sformatf("%s req flit %0d", test_name, got_req),
                    ref_payload(noc_bridge_pkg::ChanReq, got_req), noc_req_data_o, cmp_errors);
        got_req <= got_req + 1;
      end
      if (noc_rsp_valid_o && noc_rsp_ready_i) begin
        check_value($sformatf("%s rsp flit %0d", test_name, got_rsp),
                    ref_payload(noc_bridge_pkg::ChanRsp, got_rsp), noc_rsp_data_o, cmp_errors);
        got_rsp <= got_rsp + 1;
      end
      if (sent_req - got_req > MaxHeld) begin
        $display("%s: bridge holds %0d undelivered request flits, limit is %0d",
                 test_name, sent_req - got_req, MaxHeld);
        cmp_errors++;
      end
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles with flits still missing", TimeoutCycles);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int quiet;
    int last_sent;
    int credit_base;
    int wait_cycles;

    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;

    start_test("reset_state");
    check_value("reset_state valids", 32'h0,
                32'({noc_req_valid_o, noc_rsp_valid_o, axis_out_tvalid_o}), main_errors);
    finish_test();

    start_test("req_only");
    req_target = req_target + ReqOnlyFlits;
    wait_drained();
    finish_test();

    start_test("req_rsp_mix");
    req_target = req_target + MixFlits;
    rsp_target = rsp_target + MixFlits;
    wait_drained();
    finish_test();

    // Blocked request queue while response traffic keeps going
    start_test("req_backpressure");
    noc_req_ready_i = 1'b0;
    req_target      = req_target + StallReqFlits;
    rsp_target      = rsp_target + StallRspFlits;
    while (got_rsp != rsp_target) @(negedge clk_i);
    quiet     = 0;
    last_sent = sent_req;
    while (quiet < 2 * MaxHeld) begin
      @(negedge clk_i);
      if (sent_req == last_sent) begin
        quiet++;
      end else begin
        quiet     = 0;
        last_sent = sent_req;
      end
    end
    check_value("req_backpressure ready", 32'h0, 32'(noc_req_ready_o), main_errors);
    if (sent_req >= req_target) begin
      $display("req_backpressure: all request flits accepted while the queue was blocked");
      main_errors++;
    end
    noc_req_ready_i = 1'b1;
    wait_drained();
    finish_test();

    start_test("loop_random_ready");
    loop_random = 1'b1;
    req_target  = req_target + RandFlits;
    rsp_target  = rsp_target + RandFlits;
    wait_drained();
    loop_random = 1'b0;

    // Fill the request queue, then drain it with no outbound data waiting
    noc_req_ready_i = 1'b0;
    req_target      = req_target + ForceFlits;
    while (loop_data_beats != req_target + rsp_target) @(negedge clk_i);
    credit_base     = credit_only_beats;
    noc_req_ready_i = 1'b1;
    wait_drained();
    wait_cycles = 0;
    while (credit_only_beats == credit_base && wait_cycles < 4 * ForceFlits) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (credit_only_beats == credit_base) begin
      $display("loop_random_ready: no credit-only beat after draining %0d flits", ForceFlits);
      main_errors++;
    end
    finish_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d",
             tests_run, tests_failed, cmp_errors + main_errors);
    if (cmp_errors + main_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== noc_axis_bridge_sva.sv ====
// Concurrent assertions on the bridge top level, attached to every noc_axis_bridge by bind
module noc_axis_bridge_sva (
  input logic                                               clk_i,
  input logic                                               rst_i,
  input logic                                               axis_out_tvalid_i,
  input logic [noc_bridge_pkg::TdataW-1:0]                  axis_out_tdata_i,
  input logic [noc_bridge_pkg::TuserW-1:0]                  axis_out_tuser_i,
  input logic                                               axis_out_tready_i,
  input logic                                               noc_req_valid_i,
  input logic                                               noc_rsp_valid_i,
  input logic [$clog2(noc_bridge_pkg::NumCred + 1)-1:0]     req_count_i,
  input logic [$clog2(noc_bridge_pkg::NumCred + 1)-1:0]     rsp_count_i,
  input logic                                               req_push_i,
  input logic                                               rsp_push_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // A stalled AXIS beat stays put until the far side takes it
  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    axis_out_tvalid_i && !axis_out_tready_i
    |=> axis_out_tvalid_i && $stable(axis_out_tdata_i) && $stable(axis_out_tuser_i))
    else $error("AXIS output changed while stalled");

  // Nothing is offered right after a reset edge
  a_reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !axis_out_tvalid_i && !noc_req_valid_i && !noc_rsp_valid_i)
    else $error("Valid output high in the cycle after reset");

  // Credits leave room in the inbound queue for every data beat that arrives
  a_queue_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    (int'(req_count_i) + int'(req_push_i) <= noc_bridge_pkg::NumCred)
    && (int'(rsp_count_i) + int'(rsp_push_i) <= noc_bridge_pkg::NumCred))
    else $error("Inbound data beat arrived at a queue with no free slot");

endmodule

bind noc_axis_bridge noc_axis_bridge_sva u_sva (
  .clk_i             (clk_i),
  .rst_i             (rst_i),
  .axis_out_tvalid_i (axis_out_tvalid_o),
  .axis_out_tdata_i  (axis_out_tdata_o),
  .axis_out_tuser_i  (axis_out_tuser_o),
  .axis_out_tready_i (axis_out_tready_i),
  .noc_req_valid_i   (noc_req_valid_o),
  .noc_rsp_valid_i   (noc_rsp_valid_o),
  .req_count_i       (u_in_req_fifo.count_q),
  .rsp_count_i       (u_in_rsp_fifo.count_q),
  .req_push_i        (push_req),
  .rsp_push_i        (push_rsp)
);

// ==== noc_axis_bridge.sv ====
// Top level of the NoC to AXIS bridge, two virtual channels over one credit-controlled AXIS link
module noc_axis_bridge (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // NoC flits going out over the link
  input  logic                              noc_req_valid_i,
  input  logic [noc_bridge_pkg::FlitW-1:0]  noc_req_data_i,
  output logic                              noc_req_ready_o,
  input  logic                              noc_rsp_valid_i,
  input  logic [noc_bridge_pkg::FlitW-1:0]  noc_rsp_data_i,
  output logic                              noc_rsp_ready_o,
  // NoC flits received from the link
  output logic                              noc_req_valid_o,
  output logic [noc_bridge_pkg::FlitW-1:0]  noc_req_data_o,
  input  logic                              noc_req_ready_i,
  output logic                              noc_rsp_valid_o,
  output logic [noc_bridge_pkg::FlitW-1:0]  noc_rsp_data_o,
  input  logic                              noc_rsp_ready_i,
  // AXIS output
  output logic                              axis_out_tvalid_o,
  output logic [noc_bridge_pkg::TdataW-1:0] axis_out_tdata_o,
  output logic [noc_bridge_pkg::TuserW-1:0] axis_out_tuser_o,
  input  logic                              axis_out_tready_i,
  // AXIS input
  input  logic                              axis_in_tvalid_i,
  input  logic [noc_bridge_pkg::TdataW-1:0] axis_in_tdata_i,
  input  logic [noc_bridge_pkg::TuserW-1:0] axis_in_tuser_i,
  output logic                              axis_in_tready_o
);

  logic                             sync_req_valid;
  logic                             sync_rsp_valid;
  logic                             sync_req_ready;
  logic                             sync_rsp_ready;
  logic [noc_bridge_pkg::FlitW-1:0] sync_req_data;
  logic [noc_bridge_pkg::FlitW-1:0] sync_rsp_data;
  logic                             sync_req_dv;
  logic                             sync_rsp_dv;
  logic [noc_bridge_pkg::CredW-1:0] req_pending;
  logic [noc_bridge_pkg::CredW-1:0] rsp_pending;
  logic [noc_bridge_pkg::BeatW-1:0] beat_req;
  logic [noc_bridge_pkg::BeatW-1:0] beat_rsp;
  logic                             arb_valid;
  logic                             arb_ready;
  logic                             arb_fire;
  logic [noc_bridge_pkg::BeatW-1:0] arb_beat;
  logic [noc_bridge_pkg::FlitW-1:0] in_flit;
  logic                             push_req;
  logic                             push_rsp;
  logic                             push_req_ready;
  logic                             push_rsp_ready;
  logic [1:0]                       cred_rx_valid;
  logic [noc_bridge_pkg::CredW-1:0] cred_rx_count;
  logic [1:0]                       consume_pending;
  logic                             req_deliver;
  logic                             rsp_deliver;

  assign arb_fire    = arb_valid && arb_ready;
  assign req_deliver = noc_req_valid_o && noc_req_ready_i;
  assign rsp_deliver = noc_rsp_valid_o && noc_rsp_ready_i;

  ////////////////////////////////////////////////////////////
  // Outbound path
  ////////////////////////////////////////////////////////////

  credit_sync u_sync_req (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_valid_i        (noc_req_valid_i),
    .in_data_i         (noc_req_data_i),
    .in_ready_o        (noc_req_ready_o),
    .beat_valid_o      (sync_req_valid),
    .beat_data_o       (sync_req_data),
    .beat_data_valid_o (sync_req_dv),
    .beat_ready_i      (sync_req_ready),
    .cred_rx_valid_i   (cred_rx_valid[0]),
    .cred_rx_count_i   (cred_rx_count),
    .deliver_i         (req_deliver),
    .pending_o         (req_pending),
    .consume_pending_i (consume_pending[0])
  );

  credit_sync u_sync_rsp (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_valid_i        (noc_rsp_valid_i),
    .in_data_i         (noc_rsp_data_i),
    .in_ready_o        (noc_rsp_ready_o),
    .beat_valid_o      (sync_rsp_valid),
    .beat_data_o       (sync_rsp_data),
    .beat_data_valid_o (sync_rsp_dv),
    .beat_ready_i      (sync_rsp_ready),
    .cred_rx_valid_i   (cred_rx_valid[1]),
    .cred_rx_count_i   (cred_rx_count),
    .deliver_i         (rsp_deliver),
    .pending_o         (rsp_pending),
    .consume_pending_i (consume_pending[1])
  );

  rr_beat_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i ({sync_rsp_valid, sync_req_valid}),
    .req_beat_i  ({beat_rsp, beat_req}),
    .req_ready_o ({sync_rsp_ready, sync_req_ready}),
    .out_valid_o (arb_valid),
    .out_beat_o  (arb_beat),
    .out_ready_i (arb_ready)
  );

  // Keeps the AXIS beat stable under back-pressure
  flit_fifo #(
    .Depth (2),
    .Width (noc_bridge_pkg::BeatW)
  ) u_out_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (arb_valid),
    .push_data_i  (arb_beat),
    .push_ready_o (arb_ready),
    .pop_valid_o  (axis_out_tvalid_o),
    .pop_data_o   ({axis_out_tdata_o, axis_out_tuser_o}),
    .pop_ready_i  (axis_out_tready_i)
  );

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  bridge_ctrl u_ctrl (
    .pending_req_i         (req_pending),
    .pending_rsp_i         (rsp_pending),
    .req_beat_data_i       (sync_req_data),
    .req_beat_data_valid_i (sync_req_dv),
    .rsp_beat_data_i       (sync_rsp_data),
    .rsp_beat_data_valid_i (sync_rsp_dv),
    .beat_req_o            (beat_req),
    .beat_rsp_o            (beat_rsp),
    .out_beat_i            (arb_beat),
    .out_fire_i            (arb_fire),
    .axis_in_tvalid_i      (axis_in_tvalid_i),
    .axis_in_tdata_i       (axis_in_tdata_i),
    .axis_in_tuser_i       (axis_in_tuser_i),
    .axis_in_tready_o      (axis_in_tready_o),
    .in_flit_o             (in_flit),
    .push_req_o            (push_req),
    .push_rsp_o            (push_rsp),
    .push_req_ready_i      (push_req_ready),
    .push_rsp_ready_i      (push_rsp_ready),
    .cred_rx_valid_o       (cred_rx_valid),
    .cred_rx_count_o       (cred_rx_count),
    .consume_pending_o     (consume_pending)
  );

  ////////////////////////////////////////////////////////////
  // Inbound queues
  ////////////////////////////////////////////////////////////

  flit_fifo #(
    .Depth (noc_bridge_pkg::NumCred),
    .Width (noc_bridge_pkg::FlitW)
  ) u_in_req_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (push_req),
    .push_data_i  (in_flit),
    .push_ready_o (push_req_ready),
    .pop_valid_o  (noc_req_valid_o),
    .pop_data_o   (noc_req_data_o),
    .pop_ready_i  (noc_req_ready_i)
  );

  flit_fifo #(
    .Depth (noc_bridge_pkg::NumCred),
    .Width (noc_bridge_pkg::FlitW)
  ) u_in_rsp_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (push_rsp),
    .push_data_i  (in_flit),
    .push_ready_o (push_rsp_ready),
    .pop_valid_o  (noc_rsp_valid_o),
    .pop_data_o   (noc_rsp_data_o),
    .pop_ready_i  (noc_rsp_ready_i)
  );

endmodule

// ==== bridge_ctrl.sv ====
// Bridge control, assembles outbound beat words and decodes inbound AXIS beats into queue pushes and credits
module bridge_ctrl (
  // Outbound channel state
  input  logic [noc_bridge_pkg::CredW-1:0]  pending_req_i,
  input  logic [noc_bridge_pkg::CredW-1:0]  pending_rsp_i,
  input  logic [noc_bridge_pkg::FlitW-1:0]  req_beat_data_i,
  input  logic                              req_beat_data_valid_i,
  input  logic [noc_bridge_pkg::FlitW-1:0]  rsp_beat_data_i,
  input  logic                              rsp_beat_data_valid_i,
  output logic [noc_bridge_pkg::BeatW-1:0]  beat_req_o,
  output logic [noc_bridge_pkg::BeatW-1:0]  beat_rsp_o,
  // Arbiter output as accepted by the output FIFO
  input  logic [noc_bridge_pkg::BeatW-1:0]  out_beat_i,
  input  logic                              out_fire_i,
  // AXIS input
  input  logic                              axis_in_tvalid_i,
  input  logic [noc_bridge_pkg::TdataW-1:0] axis_in_tdata_i,
  input  logic [noc_bridge_pkg::TuserW-1:0] axis_in_tuser_i,
  output logic                              axis_in_tready_o,
  // Inbound queues
  output logic [noc_bridge_pkg::FlitW-1:0]  in_flit_o,
  output logic                              push_req_o,
  output logic                              push_rsp_o,
  input  logic                              push_req_ready_i,
  input  logic                              push_rsp_ready_i,
  // Credit strobes, index 0 request and index 1 response
  output logic [1:0]                        cred_rx_valid_o,
  output logic [noc_bridge_pkg::CredW-1:0]  cred_rx_count_o,
  output logic [1:0]                        consume_pending_o
);

  logic                             cred_chan;
  logic [noc_bridge_pkg::CredW-1:0] cred_count;
  logic                             out_cred_hdr;
  logic                             in_data_hdr;
  logic                             in_data_valid;
  logic                             in_cred_hdr;
  logic                             in_accept;

  ////////////////////////////////////////////////////////////
  // Outbound beat assembly
  ////////////////////////////////////////////////////////////

  // Larger owed count rides along, response wins a tie
  assign cred_chan  = (pending_req_i > pending_rsp_i) ? noc_bridge_pkg::ChanReq
                                                      : noc_bridge_pkg::ChanRsp;
  assign cred_count = (pending_req_i > pending_rsp_i) ? pending_req_i : pending_rsp_i;

  assign beat_req_o = {noc_bridge_pkg::ChanReq, req_beat_data_i, req_beat_data_valid_i,
                       cred_chan, cred_count};
  assign beat_rsp_o = {noc_bridge_pkg::ChanRsp, rsp_beat_data_i, rsp_beat_data_valid_i,
                       cred_chan, cred_count};

  // credit_hdr sits just above the credit count
  assign out_cred_hdr = out_beat_i[noc_bridge_pkg::CredW];

  assign consume_pending_o[0] = out_fire_i && (out_cred_hdr == noc_bridge_pkg::ChanReq);
  assign consume_pending_o[1] = out_fire_i && (out_cred_hdr == noc_bridge_pkg::ChanRsp);

  ////////////////////////////////////////////////////////////
  // Inbound beat decode
  ////////////////////////////////////////////////////////////

  assign {in_data_hdr, in_flit_o}                        = axis_in_tdata_i;
  assign {in_data_valid, in_cred_hdr, cred_rx_count_o}   = axis_in_tuser_i;

  assign push_req_o = axis_in_tvalid_i && in_data_valid
                      && (in_data_hdr == noc_bridge_pkg::ChanReq);
  assign push_rsp_o = axis_in_tvalid_i && in_data_valid
                      && (in_data_hdr == noc_bridge_pkg::ChanRsp);

  // Credit-only beats are always taken
  always_comb begin
    if (!in_data_valid) begin
      axis_in_tready_o = 1'b1;
    end else if (in_data_hdr == noc_bridge_pkg::ChanReq) begin
      axis_in_tready_o = push_req_ready_i;
    end else begin
      axis_in_tready_o = push_rsp_ready_i;
    end
  end

  assign in_accept = axis_in_tvalid_i && axis_in_tready_o;

  assign cred_rx_valid_o[0] = in_accept && (in_cred_hdr == noc_bridge_pkg::ChanReq);
  assign cred_rx_valid_o[1] = in_accept && (in_cred_hdr == noc_bridge_pkg::ChanRsp);

endmodule

// ==== rr_beat_arbiter.sv ====
// Two-input round-robin arbiter that merges the request and response beat words into one stream
module rr_beat_arbiter (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Index 0 is the request channel, index 1 the response channel
  input  logic [1:0]                           req_valid_i,
  input  logic [2*noc_bridge_pkg::BeatW-1:0]   req_beat_i,
  output logic [1:0]                           req_ready_o,
  output logic                                 out_valid_o,
  output logic [noc_bridge_pkg::BeatW-1:0]     out_beat_o,
  input  logic                                 out_ready_i
);

  // Input that wins when both request
  logic prio_q;
  logic sel;

  always_comb begin
    if (req_valid_i[prio_q]) begin
      sel = prio_q;
    end else begin
      sel = !prio_q;
    end
  end

  assign out_valid_o = |req_valid_i;

  assign out_beat_o = sel ? req_beat_i[2*noc_bridge_pkg::BeatW-1:noc_bridge_pkg::BeatW]
                          : req_beat_i[noc_bridge_pkg::BeatW-1:0];

  assign req_ready_o[0] = out_ready_i && !sel;
  assign req_ready_o[1] = out_ready_i && sel;

  // Priority moves past the winner only on a real transfer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      prio_q <= !sel;
    end
  end

endmodule

// ==== flit_fifo.sv ====
// Valid/ready circular-buffer FIFO, used for the inbound flit queues and the AXIS output stage
module flit_fifo #(
  parameter int Depth = 2,
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_valid_i,
  input  logic [Width-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [Width-1:0] pop_data_o,
  input  logic             pop_ready_i
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;

  // Wraps at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign push_ready_o = (count_q != CntW'(Depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CntW'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== credit_sync.sv ====
// Outbound flit register of one channel, tracks free slots on the far side and credits owed to it
module credit_sync (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Flits from the local NoC
  input  logic                             in_valid_i,
  input  logic [noc_bridge_pkg::FlitW-1:0] in_data_i,
  output logic                             in_ready_o,
  // Beat towards the arbiter
  output logic                             beat_valid_o,
  output logic [noc_bridge_pkg::FlitW-1:0] beat_data_o,
  output logic                             beat_data_valid_o,
  input  logic                             beat_ready_i,
  // Credits returned by the far side
  input  logic                             cred_rx_valid_i,
  input  logic [noc_bridge_pkg::CredW-1:0] cred_rx_count_i,
  // Credits owed to the far side
  input  logic                             deliver_i,
  output logic [noc_bridge_pkg::CredW-1:0] pending_o,
  input  logic                             consume_pending_i
);

  logic                             full_q;
  logic [noc_bridge_pkg::FlitW-1:0] flit_q;
  logic [noc_bridge_pkg::CredW-1:0] avail_q;
  logic [noc_bridge_pkg::CredW-1:0] pending_q;
  logic [noc_bridge_pkg::CredW-1:0] cred_add;
  logic [noc_bridge_pkg::CredW-1:0] sent_dec;
  logic [noc_bridge_pkg::CredW-1:0] deliver_inc;
  logic                             data_ok;
  logic                             data_fire;
  logic                             load;

  // A held flit may leave only while the far side has a free slot
  assign data_ok   = full_q && (avail_q != '0);
  assign data_fire = beat_valid_o && beat_ready_i && data_ok;

  // Register frees up in the same cycle its flit is taken
  assign in_ready_o = !full_q || data_fire;
  assign load       = in_valid_i && in_ready_o;

  // Credit-only beat when nothing can be sent and enough credits are owed
  assign beat_valid_o      = data_ok || (pending_q >= noc_bridge_pkg::ForceSendThresh);
  assign beat_data_valid_o = data_ok;
  assign beat_data_o       = flit_q;
  assign pending_o         = pending_q;

  assign cred_add    = cred_rx_valid_i ? cred_rx_count_i : '0;
  assign sent_dec    = {{(noc_bridge_pkg::CredW-1){1'b0}}, data_fire};
  assign deliver_inc = {{(noc_bridge_pkg::CredW-1){1'b0}}, deliver_i};

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q    <= 1'b0;
      avail_q   <= noc_bridge_pkg::CredInit;
      pending_q <= '0;
    end else begin
      if (load) begin
        full_q <= 1'b1;
      end else if (data_fire) begin
        full_q <= 1'b0;
      end

      avail_q <= avail_q - sent_dec + cred_add;

      // Whole count leaves with the beat, a delivery in that cycle stays owed
      if (consume_pending_i) begin
        pending_q <= deliver_inc;
      end else begin
        pending_q <= pending_q + deliver_inc;
      end
    end
  end

  // Flit payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      flit_q <= in_data_i;
    end
  end

endmodule

// ==== noc_bridge_pkg.sv ====
// Shared widths, channel codes and credit constants, referenced by scoped name from every bridge file
package noc_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // Flit and credit sizing
  ////////////////////////////////////////////////////////////

  localparam int FlitW   = 32;
  // Receive slots per channel on each side of the link
  localparam int NumCred = 8;
  localparam int CredW   = 4;

  // Credit counter reset value, the far side starts with every slot free
  localparam logic [CredW-1:0] CredInit = CredW'(NumCred);

  // Owed credits at this level go out even without data to carry them
  localparam logic [CredW-1:0] ForceSendThresh = CredW'(NumCred - 4);

  ////////////////////////////////////////////////////////////
  // Virtual channel codes
  ////////////////////////////////////////////////////////////

  // Used both as data_hdr and as credit_hdr
  localparam logic ChanReq = 1'b0;
  localparam logic ChanRsp = 1'b1;

  ////////////////////////////////////////////////////////////
  // Beat word and AXIS link widths
  ////////////////////////////////////////////////////////////

  // Beat word is {data_hdr, flit, data_valid, credit_hdr, credits}
  localparam int BeatW  = FlitW + CredW + 3;

  // tdata is {data_hdr, flit}
  localparam int TdataW = FlitW + 1;

  // tuser is {data_valid, credit_hdr, credits}
  localparam int TuserW = CredW + 2;

endpackage
